/* design/sparserdes_macros.svh */
// array size and tree depth macros for the sparse-array serializer
`ifndef SPARSERDES_MACROS_SVH
`define SPARSERDES_MACROS_SVH

// number of occupancy bits held by the store
`define SPARSE_SIZE 8

// levels of node fsms, log2 of the array size
// level 0 is the root, the last level holds the leaf nodes
`define SPARSE_DEPTH 3

`endif

/* design/sparserdes_pkg.sv */
// package with address, vector, command, stream symbol and fsm state types
`default_nettype none

`include "sparserdes_macros.svh"

package sparserdes_pkg;

    // index of one occupancy bit
    typedef logic [`SPARSE_DEPTH-1:0] leaf_addr_t;

    // whole occupancy vector, bit 0 is the lowest address
    typedef logic [`SPARSE_SIZE-1:0] leaf_vec_t;

    // host operations, encodings kept from the older controller
    typedef enum logic [2:0] {
        op_nop       = 3'b000,
        op_read      = 3'b001,
        op_serialize = 3'b011,
        op_set       = 3'b101,
        op_clear     = 3'b110
    } op_t;

    // one host command, valid for a single cycle
    typedef struct packed {
        op_t        op;
        leaf_addr_t addr;
    } cmd_t;

    // one serialized symbol, data only meaningful with valid
    typedef struct packed {
        logic valid;
        logic data;
    } stream_t;

    // walk of one tree node
    typedef enum logic [2:0] {
        node_idle      = 3'b000,
        node_emit_low  = 3'b001,
        node_emit_high = 3'b010,
        node_wait_low  = 3'b011,
        node_wait_high = 3'b100
    } node_state_t;

    // serialize run tracking
    typedef enum logic {
        ctrl_idle    = 1'b0,
        ctrl_running = 1'b1
    } ctrl_state_t;

endpackage : sparserdes_pkg

`default_nettype wire

/* design/occupancy_store.sv */
// occupancy register with bit set, clear and one-bit read
`timescale 1ns/1ps
`default_nettype none

module occupancy_store
    import sparserdes_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  cmd_t      cmd,
    input  logic      accept,
    output leaf_vec_t leaves,
    output logic      read_bit
);

    // single bit mask of the addressed leaf
    leaf_vec_t addr_mask;

    assign addr_mask = leaf_vec_t'(1) << cmd.addr;

    always_ff @(posedge clk) begin
        if (reset) begin
            leaves   <= '0;
            read_bit <= 1'b0;
        end else if (accept) begin
            case (cmd.op)
                // set and clear land on the next edge
                op_set:   leaves <= leaves | addr_mask;
                op_clear: leaves <= leaves & ~addr_mask;
                // read result held until the next read
                op_read:  read_bit <= leaves[cmd.addr];
                default: begin
                end
            endcase
        end
    end

    // a write touches only the addressed bit
    // checked against the previous vector and the previous address
    assert property (@(posedge clk) disable iff (reset)
        accept && (cmd.op == op_set || cmd.op == op_clear) |=>
            ((leaves ^ $past(leaves)) & ~$past(addr_mask)) == '0)
        else $error("store write changed a bit other than the addressed one");

endmodule : occupancy_store

`default_nettype wire

/* design/tree_node.sv */
// one serializer node fsm, emits two child flags then walks nonempty children
`timescale 1ns/1ps
`default_nettype none

module tree_node
    import sparserdes_pkg::*;
#(
    parameter bit LEAF = 1'b0
) (
    input  logic    clk,
    input  logic    reset,
    input  logic    read,
    input  logic    nonempty_low,
    input  logic    nonempty_high,
    output logic    nonempty,
    input  stream_t stream_low,
    input  stream_t stream_high,
    output stream_t stream,
    input  logic    done_low,
    input  logic    done_high,
    output logic    read_low,
    output logic    read_high,
    output logic    done
);

    node_state_t state;
    node_state_t state_next;
    logic        done_next;

    // leaf children are array bits, so their stream and done are tied off here
    stream_t child_stream_low;
    stream_t child_stream_high;
    logic    child_done_low;
    logic    child_done_high;

    assign child_stream_low  = LEAF ? stream_t'('0) : stream_low;
    assign child_stream_high = LEAF ? stream_t'('0) : stream_high;
    assign child_done_low    = LEAF ? 1'b0 : done_low;
    assign child_done_high   = LEAF ? 1'b0 : done_high;

    // subtree occupancy, purely combinational up to the root
    assign nonempty = nonempty_low | nonempty_high;

    always_comb begin
        state_next = state;
        done_next  = 1'b0;
        read_low   = 1'b0;
        read_high  = 1'b0;
        case (state)
            node_idle: begin
                if (read) begin
                    state_next = node_emit_low;
                end
            end
            node_emit_low: begin
                state_next = node_emit_high;
            end
            // descend decision made while the high flag goes out
            node_emit_high: begin
                if (LEAF) begin
                    state_next = node_idle;
                    done_next  = 1'b1;
                end else if (nonempty_low) begin
                    state_next = node_wait_low;
                    read_low   = 1'b1;
                end else if (nonempty_high) begin
                    state_next = node_wait_high;
                    read_high  = 1'b1;
                end else begin
                    // only the root gets here, empty array
                    state_next = node_idle;
                    done_next  = 1'b1;
                end
            end
            node_wait_low: begin
                if (child_done_low) begin
                    if (nonempty_high) begin
                        state_next = node_wait_high;
                        read_high  = 1'b1;
                    end else begin
                        state_next = node_idle;
                        done_next  = 1'b1;
                    end
                end
            end
            node_wait_high: begin
                if (child_done_high) begin
                    state_next = node_idle;
                    done_next  = 1'b1;
                end
            end
            default: begin
                state_next = node_idle;
            end
        endcase
    end

    // own flags first, then the active child's symbols pass straight through
    always_comb begin
        case (state)
            node_emit_low:  stream = '{valid: 1'b1, data: nonempty_low};
            node_emit_high: stream = '{valid: 1'b1, data: nonempty_high};
            node_wait_low:  stream = child_stream_low;
            node_wait_high: stream = child_stream_high;
            default:        stream = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= node_idle;
            done  <= 1'b0;
        end else begin
            state <= state_next;
            done  <= done_next;
        end
    end

    // parent only starts a walk on an idle node
    assert property (@(posedge clk) disable iff (reset) read |-> state == node_idle)
        else $error("node read while a walk is in progress");

    assert property (@(posedge clk) disable iff (reset) done |=> !done)
        else $error("node done held longer than one cycle");

    // a child is entered only when occupied, and it answers with a symbol next cycle
    assert property (@(posedge clk) disable iff (reset)
        read_low |-> nonempty_low ##1 stream_low.valid)
        else $error("low child read while empty or silent after read");

    assert property (@(posedge clk) disable iff (reset)
        read_high |-> nonempty_high ##1 stream_high.valid)
        else $error("high child read while empty or silent after read");

endmodule : tree_node

`default_nettype wire

/* design/serialize_control.sv */
// command decode, busy rule, root start strobe and done pulse
`timescale 1ns/1ps
`default_nettype none

module serialize_control
    import sparserdes_pkg::*;
(
    input  logic clk,
    input  logic reset,
    input  cmd_t cmd,
    input  logic root_done,
    output logic accept,
    output logic root_read,
    output logic busy,
    output logic done
);

    ctrl_state_t state;
    logic        known_op;

    // nop and the reserved encodings never count as a command
    assign known_op = cmd.op inside {op_read, op_set, op_clear, op_serialize};

    // commands taken only while no run is active
    assign accept = (state == ctrl_idle) && known_op;

    // root starts in the same cycle as the accepted command
    assign root_read = accept && (cmd.op == op_serialize);

    // busy follows the run state, so it rises the cycle after the command
    assign busy = (state == ctrl_running);

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= ctrl_idle;
            done  <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                ctrl_idle: begin
                    if (root_read) begin
                        state <= ctrl_running;
                    end
                end
                ctrl_running: begin
                    // busy drops and done pulses together, one cycle after the root
                    if (root_done) begin
                        state <= ctrl_idle;
                        done  <= 1'b1;
                    end
                end
                default: begin
                    state <= ctrl_idle;
                end
            endcase
        end
    end

    // the root tree must not finish a walk that was never started
    assert property (@(posedge clk) disable iff (reset) root_done |-> state == ctrl_running)
        else $error("root done seen while no serialization was running");

endmodule : serialize_control

`default_nettype wire

/* design/sparserdes.sv */
// top level with store, control and a generated tree of node fsms
`timescale 1ns/1ps
`default_nettype none

`include "sparserdes_macros.svh"

module sparserdes
    import sparserdes_pkg::*;
(
    input  logic    clk,
    input  logic    reset,
    input  cmd_t    cmd,
    output logic    read_bit,
    output stream_t stream,
    output logic    busy,
    output logic    done
);

    leaf_vec_t leaves;
    logic      accept;
    logic      root_read;

    // heap numbering: node 1 is the root, node i has children 2i and 2i+1
    // indices from SPARSE_SIZE upward are the array bits themselves
    logic [2*`SPARSE_SIZE-1:1] node_nonempty;
    logic [`SPARSE_SIZE-1:1]   node_read;
    logic [`SPARSE_SIZE-1:1]   node_done;
    stream_t                   node_stream [`SPARSE_SIZE-1:1];

    assign node_nonempty[2*`SPARSE_SIZE-1:`SPARSE_SIZE] = leaves;
    assign node_read[1] = root_read;
    assign stream = node_stream[1];

    occupancy_store u_store (
        .clk      (clk),
        .reset    (reset),
        .cmd      (cmd),
        .accept   (accept),
        .leaves   (leaves),
        .read_bit (read_bit)
    );

    serialize_control u_control (
        .clk       (clk),
        .reset     (reset),
        .cmd       (cmd),
        .root_done (node_done[1]),
        .accept    (accept),
        .root_read (root_read),
        .busy      (busy),
        .done      (done)
    );

    // level 0 is the root, the deepest level reads the array bits
    for (genvar l = 0; l < `SPARSE_DEPTH; l++) begin : level
        for (genvar n = 0; n < (1 << l); n++) begin : node
            localparam int idx = (1 << l) + n;

            if (l == `SPARSE_DEPTH - 1) begin : leaf
                // no children below, read outputs stay open
                tree_node #(.LEAF(1'b1)) u_node (
                    .clk           (clk),
                    .reset         (reset),
                    .read          (node_read[idx]),
                    .nonempty_low  (node_nonempty[2*idx]),
                    .nonempty_high (node_nonempty[2*idx+1]),
                    .nonempty      (node_nonempty[idx]),
                    .stream_low    ('0),
                    .stream_high   ('0),
                    .stream        (node_stream[idx]),
                    .done_low      (1'b0),
                    .done_high     (1'b0),
                    .read_low      (),
                    .read_high     (),
                    .done          (node_done[idx])
                );
            end else begin : inner
                tree_node #(.LEAF(1'b0)) u_node (
                    .clk           (clk),
                    .reset         (reset),
                    .read          (node_read[idx]),
                    .nonempty_low  (node_nonempty[2*idx]),
                    .nonempty_high (node_nonempty[2*idx+1]),
                    .nonempty      (node_nonempty[idx]),
                    .stream_low    (node_stream[2*idx]),
                    .stream_high   (node_stream[2*idx+1]),
                    .stream        (node_stream[idx]),
                    .done_low      (node_done[2*idx]),
                    .done_high     (node_done[2*idx+1]),
                    .read_low      (node_read[2*idx]),
                    .read_high     (node_read[2*idx+1]),
                    .done          (node_done[idx])
                );
            end
        end
    end

endmodule : sparserdes

`default_nettype wire

/* test/sparserdes_ref.svh */
// reference stream encoder and per-cycle symbol capture for the serializer testbench
`ifndef SPARSERDES_REF_SVH
`define SPARSERDES_REF_SVH

// data bits of one run, predicted and observed, first symbol first
bit expected_bits[$];
bit captured_bits[$];

// true when any array bit in [lo, lo+size) is occupied
function automatic bit range_occupied(input leaf_vec_t vec, input int lo, input int size);
    leaf_vec_t mask;
    mask = leaf_vec_t'((leaf_vec_t'(1) << size) - leaf_vec_t'(1)) << lo;
    return (vec & mask) != '0;
endfunction

// pre-order walk from the root, two flags per visited node
task automatic build_expected(input leaf_vec_t vec);
    int lo_stack[$];
    int size_stack[$];
    int lo;
    int half;
    expected_bits.delete();
    lo_stack.push_back(0);
    size_stack.push_back(`SPARSE_SIZE);
    while (lo_stack.size() > 0) begin
        lo   = lo_stack.pop_back();
        half = size_stack.pop_back() / 2;
        expected_bits.push_back(range_occupied(vec, lo, half));
        expected_bits.push_back(range_occupied(vec, lo + half, half));
        // halves of one bit are array bits, nothing below them
        if (half > 1) begin
            // high half goes on the stack first so the low half is walked first
            if (range_occupied(vec, lo + half, half)) begin
                lo_stack.push_back(lo + half);
                size_stack.push_back(half);
            end
            if (range_occupied(vec, lo, half)) begin
                lo_stack.push_back(lo);
                size_stack.push_back(half);
            end
        end
    end
endtask

// one falling edge of a run: take a valid symbol, busy must hold until done
task automatic capture_cycle(output bit finished);
    finished = done;
    if (!done) begin
        if (stream.valid) begin
            captured_bits.push_back(stream.data);
        end
        check_count++;
        assert (busy)
            else begin
                failure_count++;
                $display("busy went low during a serialization before done");
            end
    end
endtask

`endif

/* test/sparserdes_tb.sv */
// clock, reset, host stimulus, stream assertions, watchdog and summary
`timescale 1ns/1ps
`default_nettype none

`include "sparserdes_macros.svh"

module sparserdes_tb
    import sparserdes_pkg::*;
();

    localparam int clk_period     = 20;
    localparam int runs_budgeted  = 40;
    localparam int cycles_per_run = 64;

    logic    clk   = 1'b0;
    logic    reset = 1'b1;
    cmd_t    cmd   = '0;
    logic    read_bit;
    stream_t stream;
    logic    busy;
    logic    done;

    // host view of the occupancy vector
    leaf_vec_t shadow = '0;

    int check_count        = 0;
    int mismatch_count     = 0;
    int failure_count      = 0;
    int reset_state_errors = 0;
    int done_pulse_errors  = 0;
    int busy_start_errors  = 0;

    `include "sparserdes_ref.svh"

    sparserdes uut (
        .clk      (clk),
        .reset    (reset),
        .cmd      (cmd),
        .read_bit (read_bit),
        .stream   (stream),
        .busy     (busy),
        .done     (done)
    );

    always #(clk_period / 2) clk = ~clk;

    // every reset edge leaves the outputs quiet
    assert property (@(posedge clk) reset |=> !stream.valid && !done && !busy && !read_bit)
        else begin
            reset_state_errors++;
            $display("an output was high right after a reset edge");
        end

    // done lasts one cycle, after busy and the last symbol
    assert property (@(posedge clk) disable iff (reset)
        done |-> (!busy && !stream.valid) ##1 !done)
        else begin
            done_pulse_errors++;
            $display("done overlapped busy or a symbol, or lasted more than one cycle");
        end

    // a serialize taken while idle raises busy next cycle
    assert property (@(posedge clk) disable iff (reset)
        (cmd.op == op_serialize && !busy) |=> busy)
        else begin
            busy_start_errors++;
            $display("busy did not rise the cycle after a serialize command");
        end

    function automatic cmd_t make_cmd(input op_t op, input leaf_addr_t addr);
        cmd_t c;
        c.op   = op;
        c.addr = addr;
        return c;
    endfunction

    // stray traffic fired at the DUT during a run
    function automatic cmd_t random_busy_cmd();
        leaf_addr_t a;
        a = leaf_addr_t'($urandom);
        case ($urandom_range(2))
            0:       return make_cmd(op_set, a);
            1:       return make_cmd(op_clear, a);
            default: return make_cmd(op_serialize, a);
        endcase
    endfunction

    // one command for one cycle, entered and left on a falling edge
    task automatic issue(input op_t op, input leaf_addr_t addr);
        cmd = make_cmd(op, addr);
        @(negedge clk);
        cmd = make_cmd(op_nop, '0);
    endtask

    task automatic write_bit(input leaf_addr_t addr, input bit value);
        issue(value ? op_set : op_clear, addr);
        shadow[addr] = value;
    endtask

    // read_bit is registered, so it is settled one falling edge later
    task automatic check_read(input string name, input leaf_addr_t addr);
        issue(op_read, addr);
        check_count++;
        assert (read_bit == shadow[addr])
            else begin
                mismatch_count++;
                $display("MISMATCH %s: bit %0d expected %b actual %b",
                    name, addr, shadow[addr], read_bit);
            end
    endtask

    task automatic load_vector(input leaf_vec_t vec);
        leaf_addr_t a;
        for (int i = 0; i < `SPARSE_SIZE; i++) begin
            a = leaf_addr_t'(i);
            write_bit(a, vec[a]);
        end
    endtask

    // serialize the shadow contents and compare with the reference walk
    task automatic run_serialize(input string name, input bit poke);
        bit          finished;
        int          cycles;
        logic [31:0] exp_v;
        logic [31:0] act_v;
        build_expected(shadow);
        captured_bits.delete();
        finished = 1'b0;
        cycles   = 0;
        cmd      = make_cmd(op_serialize, '0);
        while (!finished && cycles < cycles_per_run) begin
            @(negedge clk);
            cycles++;
            capture_cycle(finished);
            cmd = (poke && !finished) ? random_busy_cmd() : make_cmd(op_nop, '0);
        end
        if (!finished) begin
            failure_count++;
            $display("%s: no done within %0d cycles", name, cycles_per_run);
        end
        exp_v = '0;
        act_v = '0;
        foreach (expected_bits[i]) exp_v = {exp_v[30:0], expected_bits[i]};
        foreach (captured_bits[i]) act_v = {act_v[30:0], captured_bits[i]};
        check_count++;
        assert (expected_bits.size() == captured_bits.size() && exp_v == act_v)
            else begin
                mismatch_count++;
                $display("MISMATCH %s: vector %b expected %0d symbols %b actual %0d symbols %b",
                    name, shadow, expected_bits.size(), exp_v, captured_bits.size(), act_v);
            end
    endtask

    initial begin
        int total;
        void'($urandom(24));
        repeat (5) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        check_count++;
        assert (!stream.valid && !done && !busy && !read_bit)
            else begin
                failure_count++;
                $display("outputs not all low after reset release");
            end

        // single bit writes, each read back from the store
        write_bit(3'd3, 1'b1);
        check_read("set_clear_read", 3'd3);
        check_read("set_clear_read", 3'd2);
        write_bit(3'd0, 1'b1);
        write_bit(3'd7, 1'b1);
        write_bit(3'd3, 1'b0);
        for (int i = 0; i < `SPARSE_SIZE; i++) begin
            check_read("set_clear_read", leaf_addr_t'(i));
        end

        // empty array, only the root flags
        load_vector('0);
        run_serialize("empty_array", 1'b0);
        check_count++;
        assert (captured_bits.size() == 2 && !captured_bits[0] && !captured_bits[1])
            else begin
                mismatch_count++;
                $display("MISMATCH empty_array: expected 2 symbols 00 actual %0d symbols",
                    captured_bits.size());
            end

        for (int i = 0; i < `SPARSE_SIZE; i++) begin
            load_vector(leaf_vec_t'(1) << i);
            run_serialize("single_bit", 1'b0);
        end
        load_vector('1);
        run_serialize("full_array", 1'b0);
        for (int i = 0; i < 30; i++) begin
            load_vector(leaf_vec_t'($urandom));
            run_serialize("random_vector", 1'b0);
        end

        // writes and serializes during a run are dropped
        for (int i = 0; i < 2; i++) begin
            load_vector(leaf_vec_t'($urandom));
            run_serialize("busy_commands", 1'b1);
            for (int j = 0; j < `SPARSE_SIZE; j++) begin
                check_read("busy_commands", leaf_addr_t'(j));
            end
        end

        total = mismatch_count + failure_count + reset_state_errors
            + done_pulse_errors + busy_start_errors;
        $display("summary: %0d checks, %0d mismatches, %0d other failures, %0d protocol errors",
            check_count, mismatch_count, failure_count,
            reset_state_errors + done_pulse_errors + busy_start_errors);
        if (total == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

    // run length bound from the serialization budget
    initial begin
        #(runs_budgeted * cycles_per_run * clk_period);
        $display("timeout: the testbench did not finish in the cycle budget");
        $display("CHECKS FAILED");
        $finish;
    end

endmodule : sparserdes_tb

`default_nettype wire

/* sparserdes.f */
+incdir+design
+incdir+test
design/sparserdes_pkg.sv
design/occupancy_store.sv
design/tree_node.sv
design/serialize_control.sv
design/sparserdes.sv
test/sparserdes_tb.sv

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -f sparserdes.f \
    --top-module sparserdes_tb -o sparserdes_sim \
    && ./obj_dir/sparserdes_sim > sim.log 2>&1 \
    || { echo "build or simulation error"; cat sim.log 2>/dev/null; exit 1; }

cat sim.log
grep -q "CHECKS FAILED" sim.log && { echo "simulation reported failure"; exit 1; }
grep -q "ALL CHECKS PASSED" sim.log || { echo "no pass message in the log"; exit 1; }
echo "simulation passed"
exit 0
